/* include/lvdc_params.svh */
`ifndef LVDC_PARAMS_SVH
`define LVDC_PARAMS_SVH

// data word length, also the instruction length
`define LVDC_WORD_BITS      26

`define LVDC_OP_BITS        4   // top of instruction
`define LVDC_OPERAND_BITS   22  // low bits, immediate

`define LVDC_BIT_COUNT_BITS 5

`endif

/* design/lvdc_pkg.sv */
`default_nettype none

`include "lvdc_params.svh"

package lvdc_pkg;

    typedef logic [`LVDC_WORD_BITS-1:0]      accWord_t;
    typedef logic [`LVDC_OPERAND_BITS-1:0]   operand_t;
    typedef logic [`LVDC_BIT_COUNT_BITS-1:0] bitCount_t;

    typedef enum logic {
        PHASE_FETCH = 1'b0,
        PHASE_EXEC  = 1'b1
    } wordPhase_t;

    // 7..15 unused, treated as nop
    typedef enum logic [`LVDC_OP_BITS-1:0] {
        OP_NOP = 4'd0, OP_LOD = 4'd1, OP_ADD = 4'd2, OP_SUB = 4'd3,
        OP_AND = 4'd4, OP_SHR = 4'd5, OP_HLT = 4'd6
    } opcode_t;

endpackage

`default_nettype wire

/* design/bitTiming.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lvdc_params.svh"

module bitTiming (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               running,
    output lvdc_pkg::bitCount_t     bitCount,
    output lvdc_pkg::wordPhase_t    wordPhase,
    output logic                    wordEnd
);
    import lvdc_pkg::*;

    logic lastBit;

    assign lastBit = (bitCount == bitCount_t'(`LVDC_WORD_BITS - 1));
    assign wordEnd = running & lastBit;

    // --------------------------------------------------
    // bit time counter and word phase
    always_ff @(posedge clk) begin
        if (rst || !running) begin
            bitCount  <= '0;            // parked at fetch bit 0
            wordPhase <= PHASE_FETCH;
        end else if (lastBit) begin
            bitCount  <= '0;
            wordPhase <= (wordPhase == PHASE_FETCH) ? PHASE_EXEC : PHASE_FETCH;
        end else begin
            bitCount  <= bitCount + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/transferRegister.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lvdc_params.svh"

module transferRegister (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               din,
    input  wire logic               running,
    input  lvdc_pkg::bitCount_t     bitCount,
    input  lvdc_pkg::wordPhase_t    wordPhase,
    output lvdc_pkg::opcode_t       opField,
    output logic                    operandBit
);
    import lvdc_pkg::*;

    accWord_t shreg;

    // --------------------------------------------------
    // serial in during fetch, serial out during execute
    always_ff @(posedge clk) begin
        if (rst) begin
            shreg <= '0;
        end else if (running) begin
            if (wordPhase == PHASE_FETCH)
                shreg <= {din, shreg[`LVDC_WORD_BITS-1:1]};
            else
                shreg <= {1'b0, shreg[`LVDC_WORD_BITS-1:1]};
        end
    end

    // msb of op code is still on din at the fetch word end
    assign opField = opcode_t'({din, shreg[`LVDC_WORD_BITS-1 -: `LVDC_OP_BITS-1]});

    // op code bits read as zero, operand zero extended
    assign operandBit = (bitCount < bitCount_t'(`LVDC_OPERAND_BITS)) ? shreg[0] : 1'b0;

endmodule

`default_nettype wire

/* design/opcodeRegister.sv */
`timescale 1ns/1ns
`default_nettype none

module opcodeRegister (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               wordEnd,
    input  lvdc_pkg::wordPhase_t    wordPhase,
    input  lvdc_pkg::opcode_t       opField,
    output lvdc_pkg::opcode_t       opcode,
    output logic                    isHalt
);
    import lvdc_pkg::*;

    opcode_t legalOp;

    always_comb begin
        case (opField)
            OP_NOP, OP_LOD, OP_ADD, OP_SUB,
            OP_AND, OP_SHR, OP_HLT: legalOp = opField;
            default:                legalOp = OP_NOP;   // undefined codes
        endcase
    end

    // --------------------------------------------------
    // latch at end of fetch, hold through execute
    always_ff @(posedge clk) begin
        if (rst)
            opcode <= OP_NOP;
        else if (wordEnd && wordPhase == PHASE_FETCH)
            opcode <= legalOp;
    end

    assign isHalt = (opcode == OP_HLT);

endmodule

`default_nettype wire

/* design/accumulatorDelayLine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lvdc_params.svh"

module accumulatorDelayLine (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               resultBit,
    input  lvdc_pkg::wordPhase_t    wordPhase,
    output lvdc_pkg::accWord_t      acc,
    output logic                    accBit,
    output logic                    accNextBit,
    output logic                    accSign
);
    import lvdc_pkg::*;

    logic signReg;  // sign of the word entering execute

    always_ff @(posedge clk) begin
        if (rst) begin
            acc     <= '0;
            signReg <= 1'b0;
        end else if (wordPhase == PHASE_EXEC) begin
            acc <= {resultBit, acc[`LVDC_WORD_BITS-1:1]};  // recirculate
        end else begin
            signReg <= acc[`LVDC_WORD_BITS-1];
        end
    end

    assign accBit     = acc[0];
    assign accNextBit = acc[1];
    assign accSign    = signReg;

endmodule

`default_nettype wire

/* design/serialArithmetic.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lvdc_params.svh"

module serialArithmetic (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               accBit,
    input  wire logic               accNextBit,
    input  wire logic               accSign,
    input  wire logic               operandBit,
    input  lvdc_pkg::bitCount_t     bitCount,
    input  lvdc_pkg::wordPhase_t    wordPhase,
    input  lvdc_pkg::opcode_t       opcode,
    output logic                    resultBit
);
    import lvdc_pkg::*;

    logic carry;
    logic carryIn;
    logic addB;
    logic sumBit;
    logic carryOut;

    // two's complement subtract, invert b and carry in a one at bit 0
    assign addB     = (opcode == OP_SUB) ? ~operandBit : operandBit;
    assign carryIn  = (bitCount == '0) ? (opcode == OP_SUB) : carry;
    assign sumBit   = accBit ^ addB ^ carryIn;
    assign carryOut = (accBit & addB) | (carryIn & (accBit ^ addB));

    always_ff @(posedge clk) begin
        if (rst)
            carry <= 1'b0;
        else if (wordPhase == PHASE_EXEC)
            carry <= carryOut;
    end

    always_comb begin
        case (opcode)
            OP_LOD:         resultBit = operandBit;
            OP_ADD, OP_SUB: resultBit = sumBit;
            OP_AND:         resultBit = accBit & operandBit;
            OP_SHR:         resultBit = (bitCount == bitCount_t'(`LVDC_WORD_BITS - 1)) ?
                                        accSign : accNextBit;   // sign fill
            default:        resultBit = accBit;
        endcase
    end

endmodule

`default_nettype wire

/* design/runControl.sv */
`timescale 1ns/1ns
`default_nettype none

module runControl (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               start,
    input  wire logic               halt,
    input  wire logic               isHalt,
    input  wire logic               wordEnd,
    input  lvdc_pkg::wordPhase_t    wordPhase,
    output logic                    running,
    output logic                    instrDone
);
    import lvdc_pkg::*;

    logic execEnd;

    assign execEnd = wordEnd && (wordPhase == PHASE_EXEC);

    // --------------------------------------------------
    // run flip-flop
    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            instrDone <= 1'b0;
        end else begin
            instrDone <= execEnd;
            if (!running && start)
                running <= 1'b1;
            else if (execEnd && (halt || isHalt))
                running <= 1'b0;    // stop after this instruction
        end
    end

endmodule

`default_nettype wire

/* design/lvdc.sv */
`timescale 1ns/1ns
`default_nettype none

module lvdc (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           start,
    input  wire logic           halt,
    input  wire logic           din,
    output lvdc_pkg::accWord_t  acc,
    output logic                running,
    output logic                instrDone
);
    import lvdc_pkg::*;

    bitCount_t  bitCount;
    wordPhase_t wordPhase;
    logic       wordEnd;
    opcode_t    opField;
    opcode_t    opcode;
    logic       isHalt;
    logic       operandBit;
    logic       accBit;
    logic       accNextBit;
    logic       accSign;
    logic       resultBit;

    // --------------------------------------------------
    // timing and control
    bitTiming timing (
        .clk(clk), .rst(rst), .running(running),
        .bitCount(bitCount), .wordPhase(wordPhase), .wordEnd(wordEnd)
    );

    runControl runCtl (
        .clk(clk), .rst(rst), .start(start), .halt(halt), .isHalt(isHalt),
        .wordEnd(wordEnd), .wordPhase(wordPhase),
        .running(running), .instrDone(instrDone)
    );

    // --------------------------------------------------
    // instruction path
    transferRegister xferReg (
        .clk(clk), .rst(rst), .din(din), .running(running),
        .bitCount(bitCount), .wordPhase(wordPhase),
        .opField(opField), .operandBit(operandBit)
    );

    opcodeRegister opReg (
        .clk(clk), .rst(rst), .wordEnd(wordEnd), .wordPhase(wordPhase),
        .opField(opField), .opcode(opcode), .isHalt(isHalt)
    );

    // data path
    serialArithmetic arith (
        .clk(clk), .rst(rst), .accBit(accBit), .accNextBit(accNextBit),
        .accSign(accSign), .operandBit(operandBit), .bitCount(bitCount),
        .wordPhase(wordPhase), .opcode(opcode), .resultBit(resultBit)
    );

    accumulatorDelayLine accLine (
        .clk(clk), .rst(rst), .resultBit(resultBit), .wordPhase(wordPhase),
        .acc(acc), .accBit(accBit), .accNextBit(accNextBit), .accSign(accSign)
    );

endmodule

`default_nettype wire

/* dv/lvdc_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module lvdc_chk (
    input wire logic clk,
    input wire logic rst,
    input wire logic running,
    input wire logic instrDone
);

    // one-cycle strobe
    doneSingle: assert property (@(posedge clk) disable iff (rst) instrDone |=> !instrDone)
        else $error("instrDone high for more than one cycle");

    doneWhileRunning: assert property (@(posedge clk) disable iff (rst)
        $rose(instrDone) |-> $past(running))
        else $error("instrDone rose while the machine was stopped");

    stoppedAfterReset: assert property (@(posedge clk) rst |=> !running)
        else $error("running high after reset");

endmodule

bind lvdc lvdc_chk lvdcChk (
    .clk(clk), .rst(rst), .running(running), .instrDone(instrDone)
);

`default_nettype wire

/* dv/lvdc_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lvdc_params.svh"

module lvdc_tb;
    import lvdc_pkg::*;

    localparam string TEST_FILE = "dv/lvdc_tests.txt";

    logic       clk;
    logic       rst;
    logic       start;
    logic       halt;
    logic       din;
    accWord_t   acc;
    logic       running;
    logic       instrDone;

    logic [`LVDC_OP_BITS-1:0] opQ[$];
    operand_t                 operandQ[$];
    logic                     haltQ[$];
    accWord_t                 expQ[$];

    logic [31:0] rngState;
    logic        expectRunning;
    int          cycleCount;
    int          cycleLimit;

    lvdc lvdc_inst (
        .clk(clk), .rst(rst), .start(start), .halt(halt), .din(din),
        .acc(acc), .running(running), .instrDone(instrDone)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkAcc(input accWord_t actual, input accWord_t expected);
        if (actual !== expected)
            abortRun($sformatf("FAILED acc: got %h, expected %h", actual, expected));
    endtask

    task automatic checkRunning(input logic actual, input logic expected);
        if (actual !== expected)
            abortRun($sformatf("FAILED running: got %h, expected %h", actual, expected));
    endtask

    task automatic readTests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] op;
        logic [31:0] operand;
        logic [31:0] haltLvl;
        logic [31:0] expected;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abortRun("could not open the test data file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h", op, operand, haltLvl, expected);
                if (n == 4) begin   // comment and blank lines skipped
                    opQ.push_back(op[`LVDC_OP_BITS-1:0]);
                    operandQ.push_back(operand[`LVDC_OPERAND_BITS-1:0]);
                    haltQ.push_back(haltLvl[0]);
                    expQ.push_back(expected[`LVDC_WORD_BITS-1:0]);
                end
            end
            $fclose(fd);
        end
    endtask

    // starts on a falling edge, returns on the falling edge that sees instrDone
    task automatic runInstruction(input logic [`LVDC_OP_BITS-1:0] op,
                                  input operand_t operand, input logic haltLvl);
        accWord_t word;
        word = {op, operand};
        halt = haltLvl;
        if (!expectRunning) begin
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        for (int i = 0; i < `LVDC_WORD_BITS; i++) begin
            din = word[i];  // lsb first
            @(negedge clk);
        end
        din = 1'b0;
        while (!instrDone)
            @(negedge clk);
    endtask

    // --------------------------------------------------
    // timeout
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
            abortRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
    end

    // --------------------------------------------------
    // main sequence
    initial begin
        operand_t operand;
        rst           = 1'b1;
        start         = 1'b0;
        halt          = 1'b0;
        din           = 1'b0;
        rngState      = 32'hfba394db;
        expectRunning = 1'b0;
        cycleCount    = 0;
        cycleLimit    = 0;
        readTests();
        cycleLimit = opQ.size() * 60 + 40;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        repeat (3) begin
            @(negedge clk);
            checkAcc(acc, '0);
            checkRunning(running, 1'b0);
        end

        for (int t = 0; t < opQ.size(); t++) begin
            operand = operandQ[t];
            if (opQ[t] == OP_NOP) begin
                rngState = xorshift32(rngState);
                operand  = rngState[`LVDC_OPERAND_BITS-1:0];
            end
            runInstruction(opQ[t], operand, haltQ[t]);
            expectRunning = !((opQ[t] == OP_HLT) || haltQ[t]);
            checkAcc(acc, expQ[t]);
            checkRunning(running, expectRunning);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/lvdc_tests.txt */
// op operand halt expected_acc, all hex; op 0 lines get a random operand
1 3fffff 0 03fffff
2 3fffff 0 07ffffe
3 0001ff 0 07ffdff
1 000005 0 0000005
3 000007 0 3fffffe
2 000003 0 0000001
0 000000 0 0000001
3 000004 0 3fffffd
5 123456 0 3fffffe
4 2aaaaa 0 02aaaaa
6 000000 0 02aaaaa
9 3fffff 1 02aaaaa
0 000000 0 02aaaaa

/* filelist.f */
+incdir+include
design/lvdc_pkg.sv
design/bitTiming.sv
design/transferRegister.sv
design/opcodeRegister.sv
design/accumulatorDelayLine.sv
design/serialArithmetic.sv
design/runControl.sv
design/lvdc.sv
dv/lvdc_chk.sv
dv/lvdc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := lvdc_tb
FILELIST  := filelist.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJDIR)
